//--- hdl/iq_defs.svh
`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// queue geometry
`define IQ_ENTRIES 8

// physical register file
`define PR_COUNT 64
`define LOG_PR_COUNT $clog2(`PR_COUNT)
`define PRF_BANK_COUNT 4
`define LOG_PRF_BANK_COUNT $clog2(`PRF_BANK_COUNT)
`define PR_UPPER_WIDTH (`LOG_PR_COUNT - `LOG_PRF_BANK_COUNT)

// operation fields
`define CQ_INDEX_WIDTH 3
`define OP_WIDTH 4
`define IMM_WIDTH 12

`endif

//--- hdl/prf_pkg.sv
`include "iq_defs.svh"

package prf_pkg;

    // physical register number, whole or split into upper and bank
    typedef struct packed {
        logic [`PR_UPPER_WIDTH-1:0] upper;
        logic [`LOG_PRF_BANK_COUNT-1:0] bank;
    } pr_fields_t;

    typedef union packed {
        logic [`LOG_PR_COUNT-1:0] idx;
        pr_fields_t f;
    } pr_u;

endpackage

//--- hdl/stamofu_iq.sv
`include "iq_defs.svh"

module stamofu_iq (
    input  logic CLK,
    input  logic nRST,

    // enqueue
    input  logic enq_valid,
    input  logic enq_is_store,
    input  logic enq_is_amo,
    input  logic enq_is_fence,
    input  logic [`OP_WIDTH-1:0] enq_op,
    input  logic [`IMM_WIDTH-1:0] enq_imm12,
    input  prf_pkg::pr_u enq_a_pr,
    input  logic enq_a_ready,
    input  logic enq_a_is_zero,
    input  prf_pkg::pr_u enq_b_pr,
    input  logic enq_b_ready,
    input  logic enq_b_is_zero,
    input  logic [`CQ_INDEX_WIDTH-1:0] enq_cq_index,
    output logic enq_ready,

    // writeback bus
    input  logic [`PRF_BANK_COUNT-1:0] wb_valid_by_bank,
    input  logic [`PRF_BANK_COUNT-1:0][`PR_UPPER_WIDTH-1:0] wb_upper_pr_by_bank,

    // pipeline issue
    input  logic issue_ready,
    output logic issue_valid,
    output logic issue_is_store,
    output logic issue_is_amo,
    output logic issue_is_fence,
    output logic [`OP_WIDTH-1:0] issue_op,
    output logic [`IMM_WIDTH-1:0] issue_imm12,
    output logic issue_a_is_reg,
    output logic issue_a_is_bus_forward,
    output logic [`LOG_PRF_BANK_COUNT-1:0] issue_a_bank,
    output logic issue_b_is_reg,
    output logic issue_b_is_bus_forward,
    output logic [`LOG_PRF_BANK_COUNT-1:0] issue_b_bank,
    output logic [`CQ_INDEX_WIDTH-1:0] issue_cq_index,

    // register file read requests
    output logic prf_req_a_valid,
    output logic [`LOG_PR_COUNT-1:0] prf_req_a_pr,
    output logic prf_req_b_valid,
    output logic [`LOG_PR_COUNT-1:0] prf_req_b_pr
);

    // one extra index above the top slot, tied empty
    logic [`IQ_ENTRIES:0] valid_by_entry;
    logic [`IQ_ENTRIES:0] is_store_by_entry;
    logic [`IQ_ENTRIES:0] is_amo_by_entry;
    logic [`IQ_ENTRIES:0] is_fence_by_entry;
    logic [`IQ_ENTRIES:0][`OP_WIDTH-1:0] op_by_entry;
    logic [`IQ_ENTRIES:0][`IMM_WIDTH-1:0] imm12_by_entry;
    prf_pkg::pr_u [`IQ_ENTRIES:0] a_pr_by_entry;
    logic [`IQ_ENTRIES:0] a_ready_by_entry;
    logic [`IQ_ENTRIES:0] a_is_zero_by_entry;
    prf_pkg::pr_u [`IQ_ENTRIES:0] b_pr_by_entry;
    logic [`IQ_ENTRIES:0] b_ready_by_entry;
    logic [`IQ_ENTRIES:0] b_is_zero_by_entry;
    logic [`IQ_ENTRIES:0][`CQ_INDEX_WIDTH-1:0] cq_index_by_entry;
    logic [`IQ_ENTRIES:0] dispatch_write;

    logic [`IQ_ENTRIES-1:0] a_bus_fwd_by_entry;
    logic [`IQ_ENTRIES-1:0] b_bus_fwd_by_entry;
    logic [`IQ_ENTRIES-1:0] collapse_mask;

    assign valid_by_entry[`IQ_ENTRIES] = 1'b0;
    assign is_store_by_entry[`IQ_ENTRIES] = 1'b0;
    assign is_amo_by_entry[`IQ_ENTRIES] = 1'b0;
    assign is_fence_by_entry[`IQ_ENTRIES] = 1'b0;
    assign op_by_entry[`IQ_ENTRIES] = '0;
    assign imm12_by_entry[`IQ_ENTRIES] = '0;
    assign a_pr_by_entry[`IQ_ENTRIES] = '0;
    assign a_ready_by_entry[`IQ_ENTRIES] = 1'b0;
    assign a_is_zero_by_entry[`IQ_ENTRIES] = 1'b0;
    assign b_pr_by_entry[`IQ_ENTRIES] = '0;
    assign b_ready_by_entry[`IQ_ENTRIES] = 1'b0;
    assign b_is_zero_by_entry[`IQ_ENTRIES] = 1'b0;
    assign cq_index_by_entry[`IQ_ENTRIES] = '0;
    assign dispatch_write[`IQ_ENTRIES] = 1'b0;

    stamofu_iq_dispatch dispatch_inst (
        .enq_valid(enq_valid),
        .valid_by_entry(valid_by_entry[`IQ_ENTRIES-1:0]),
        .enq_ready(enq_ready),
        .dispatch_write_by_entry(dispatch_write[`IQ_ENTRIES-1:0])
    );

    // ------------------------------------------------------------------------
    // slots, each chained to the one above

    for (genvar i = 0; i < `IQ_ENTRIES; i++) begin : g_entry
        stamofu_iq_entry entry_inst (
            .CLK(CLK),
            .nRST(nRST),
            .take_above(collapse_mask[i]),
            .dispatch_here(dispatch_write[i]),
            .dispatch_above(dispatch_write[i+1]),
            .above_valid(valid_by_entry[i+1]),
            .above_is_store(is_store_by_entry[i+1]),
            .above_is_amo(is_amo_by_entry[i+1]),
            .above_is_fence(is_fence_by_entry[i+1]),
            .above_op(op_by_entry[i+1]),
            .above_imm12(imm12_by_entry[i+1]),
            .above_a_pr(a_pr_by_entry[i+1]),
            .above_a_ready(a_ready_by_entry[i+1]),
            .above_a_is_zero(a_is_zero_by_entry[i+1]),
            .above_b_pr(b_pr_by_entry[i+1]),
            .above_b_ready(b_ready_by_entry[i+1]),
            .above_b_is_zero(b_is_zero_by_entry[i+1]),
            .above_cq_index(cq_index_by_entry[i+1]),
            .enq_is_store(enq_is_store),
            .enq_is_amo(enq_is_amo),
            .enq_is_fence(enq_is_fence),
            .enq_op(enq_op),
            .enq_imm12(enq_imm12),
            .enq_a_pr(enq_a_pr),
            .enq_a_ready(enq_a_ready),
            .enq_a_is_zero(enq_a_is_zero),
            .enq_b_pr(enq_b_pr),
            .enq_b_ready(enq_b_ready),
            .enq_b_is_zero(enq_b_is_zero),
            .enq_cq_index(enq_cq_index),
            .wb_valid_by_bank(wb_valid_by_bank),
            .wb_upper_pr_by_bank(wb_upper_pr_by_bank),
            .valid(valid_by_entry[i]),
            .is_store(is_store_by_entry[i]),
            .is_amo(is_amo_by_entry[i]),
            .is_fence(is_fence_by_entry[i]),
            .op(op_by_entry[i]),
            .imm12(imm12_by_entry[i]),
            .a_pr(a_pr_by_entry[i]),
            .a_ready(a_ready_by_entry[i]),
            .a_is_zero(a_is_zero_by_entry[i]),
            .a_bus_fwd(a_bus_fwd_by_entry[i]),
            .b_pr(b_pr_by_entry[i]),
            .b_ready(b_ready_by_entry[i]),
            .b_is_zero(b_is_zero_by_entry[i]),
            .b_bus_fwd(b_bus_fwd_by_entry[i]),
            .cq_index(cq_index_by_entry[i])
        );
    end

    stamofu_iq_issue issue_inst (
        .issue_ready(issue_ready),
        .valid_by_entry(valid_by_entry[`IQ_ENTRIES-1:0]),
        .is_store_by_entry(is_store_by_entry[`IQ_ENTRIES-1:0]),
        .is_amo_by_entry(is_amo_by_entry[`IQ_ENTRIES-1:0]),
        .is_fence_by_entry(is_fence_by_entry[`IQ_ENTRIES-1:0]),
        .op_by_entry(op_by_entry[`IQ_ENTRIES-1:0]),
        .imm12_by_entry(imm12_by_entry[`IQ_ENTRIES-1:0]),
        .a_pr_by_entry(a_pr_by_entry[`IQ_ENTRIES-1:0]),
        .a_ready_by_entry(a_ready_by_entry[`IQ_ENTRIES-1:0]),
        .a_is_zero_by_entry(a_is_zero_by_entry[`IQ_ENTRIES-1:0]),
        .a_bus_fwd_by_entry(a_bus_fwd_by_entry),
        .b_pr_by_entry(b_pr_by_entry[`IQ_ENTRIES-1:0]),
        .b_ready_by_entry(b_ready_by_entry[`IQ_ENTRIES-1:0]),
        .b_is_zero_by_entry(b_is_zero_by_entry[`IQ_ENTRIES-1:0]),
        .b_bus_fwd_by_entry(b_bus_fwd_by_entry),
        .cq_index_by_entry(cq_index_by_entry[`IQ_ENTRIES-1:0]),
        .issue_valid(issue_valid),
        .issue_is_store(issue_is_store),
        .issue_is_amo(issue_is_amo),
        .issue_is_fence(issue_is_fence),
        .issue_op(issue_op),
        .issue_imm12(issue_imm12),
        .issue_a_is_reg(issue_a_is_reg),
        .issue_a_is_bus_forward(issue_a_is_bus_forward),
        .issue_a_bank(issue_a_bank),
        .issue_b_is_reg(issue_b_is_reg),
        .issue_b_is_bus_forward(issue_b_is_bus_forward),
        .issue_b_bank(issue_b_bank),
        .issue_cq_index(issue_cq_index),
        .prf_req_a_valid(prf_req_a_valid),
        .prf_req_a_pr(prf_req_a_pr),
        .prf_req_b_valid(prf_req_b_valid),
        .prf_req_b_pr(prf_req_b_pr),
        .collapse_mask(collapse_mask)
    );

endmodule

//--- hdl/stamofu_iq_dispatch.sv
`include "iq_defs.svh"

module stamofu_iq_dispatch (
    input  logic enq_valid,
    input  logic [`IQ_ENTRIES-1:0] valid_by_entry,
    output logic enq_ready,
    output logic [`IQ_ENTRIES-1:0] dispatch_write_by_entry
);

    logic [`IQ_ENTRIES-1:0] open_mask;
    logic [`IQ_ENTRIES-1:0] open_one_hot;

    assign open_mask = ~valid_by_entry;

    // lowest free slot
    assign open_one_hot = open_mask & (~open_mask + 1'b1);

    assign dispatch_write_by_entry = open_one_hot & {`IQ_ENTRIES{enq_valid}};
    assign enq_ready = |open_mask;

endmodule

//--- hdl/stamofu_iq_entry.sv
`include "iq_defs.svh"

module stamofu_iq_entry (
    input  logic CLK,
    input  logic nRST,

    // collapse and dispatch control
    input  logic take_above,
    input  logic dispatch_here,
    input  logic dispatch_above,

    // slot above
    input  logic above_valid,
    input  logic above_is_store,
    input  logic above_is_amo,
    input  logic above_is_fence,
    input  logic [`OP_WIDTH-1:0] above_op,
    input  logic [`IMM_WIDTH-1:0] above_imm12,
    input  prf_pkg::pr_u above_a_pr,
    input  logic above_a_ready,
    input  logic above_a_is_zero,
    input  prf_pkg::pr_u above_b_pr,
    input  logic above_b_ready,
    input  logic above_b_is_zero,
    input  logic [`CQ_INDEX_WIDTH-1:0] above_cq_index,

    // enqueue operation
    input  logic enq_is_store,
    input  logic enq_is_amo,
    input  logic enq_is_fence,
    input  logic [`OP_WIDTH-1:0] enq_op,
    input  logic [`IMM_WIDTH-1:0] enq_imm12,
    input  prf_pkg::pr_u enq_a_pr,
    input  logic enq_a_ready,
    input  logic enq_a_is_zero,
    input  prf_pkg::pr_u enq_b_pr,
    input  logic enq_b_ready,
    input  logic enq_b_is_zero,
    input  logic [`CQ_INDEX_WIDTH-1:0] enq_cq_index,

    // writeback bus
    input  logic [`PRF_BANK_COUNT-1:0] wb_valid_by_bank,
    input  logic [`PRF_BANK_COUNT-1:0][`PR_UPPER_WIDTH-1:0] wb_upper_pr_by_bank,

    // slot state
    output logic valid,
    output logic is_store,
    output logic is_amo,
    output logic is_fence,
    output logic [`OP_WIDTH-1:0] op,
    output logic [`IMM_WIDTH-1:0] imm12,
    output prf_pkg::pr_u a_pr,
    output logic a_ready,
    output logic a_is_zero,
    output logic a_bus_fwd,
    output prf_pkg::pr_u b_pr,
    output logic b_ready,
    output logic b_is_zero,
    output logic b_bus_fwd,
    output logic [`CQ_INDEX_WIDTH-1:0] cq_index
);

    logic a_ready_q;
    logic b_ready_q;

    // ------------------------------------------------------------------------
    // writeback wakeup

    // a zero operand never reads the bus
    assign a_bus_fwd = wb_valid_by_bank[a_pr.f.bank] & ~a_is_zero
        & (wb_upper_pr_by_bank[a_pr.f.bank] == a_pr.f.upper);
    assign b_bus_fwd = wb_valid_by_bank[b_pr.f.bank] & ~b_is_zero
        & (wb_upper_pr_by_bank[b_pr.f.bank] == b_pr.f.upper);

    assign a_ready = a_ready_q | a_bus_fwd | a_is_zero;
    assign b_ready = b_ready_q | b_bus_fwd | b_is_zero;

    // ------------------------------------------------------------------------
    // next state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid <= 1'b0;
        end else if (take_above) begin
            valid <= above_valid | dispatch_above;
        end else begin
            valid <= valid | dispatch_here;
        end
    end

    always_ff @(posedge CLK) begin
        if (take_above && above_valid) begin
            is_store <= above_is_store;
            is_amo <= above_is_amo;
            is_fence <= above_is_fence;
            op <= above_op;
            imm12 <= above_imm12;
            a_pr <= above_a_pr;
            a_ready_q <= above_a_ready;
            a_is_zero <= above_a_is_zero;
            b_pr <= above_b_pr;
            b_ready_q <= above_b_ready;
            b_is_zero <= above_b_is_zero;
            cq_index <= above_cq_index;
        end else if (!take_above && valid) begin
            // hold, with this cycle's wakeup kept
            a_ready_q <= a_ready;
            b_ready_q <= b_ready;
        end else begin
            is_store <= enq_is_store;
            is_amo <= enq_is_amo;
            is_fence <= enq_is_fence;
            op <= enq_op;
            imm12 <= enq_imm12;
            a_pr <= enq_a_pr;
            a_ready_q <= enq_a_ready;
            a_is_zero <= enq_a_is_zero;
            b_pr <= enq_b_pr;
            b_ready_q <= enq_b_ready;
            b_is_zero <= enq_b_is_zero;
            cq_index <= enq_cq_index;
        end
    end

endmodule

//--- hdl/stamofu_iq_issue.sv
`include "iq_defs.svh"

module stamofu_iq_issue (
    input  logic issue_ready,

    // slot state
    input  logic [`IQ_ENTRIES-1:0] valid_by_entry,
    input  logic [`IQ_ENTRIES-1:0] is_store_by_entry,
    input  logic [`IQ_ENTRIES-1:0] is_amo_by_entry,
    input  logic [`IQ_ENTRIES-1:0] is_fence_by_entry,
    input  logic [`IQ_ENTRIES-1:0][`OP_WIDTH-1:0] op_by_entry,
    input  logic [`IQ_ENTRIES-1:0][`IMM_WIDTH-1:0] imm12_by_entry,
    input  prf_pkg::pr_u [`IQ_ENTRIES-1:0] a_pr_by_entry,
    input  logic [`IQ_ENTRIES-1:0] a_ready_by_entry,
    input  logic [`IQ_ENTRIES-1:0] a_is_zero_by_entry,
    input  logic [`IQ_ENTRIES-1:0] a_bus_fwd_by_entry,
    input  prf_pkg::pr_u [`IQ_ENTRIES-1:0] b_pr_by_entry,
    input  logic [`IQ_ENTRIES-1:0] b_ready_by_entry,
    input  logic [`IQ_ENTRIES-1:0] b_is_zero_by_entry,
    input  logic [`IQ_ENTRIES-1:0] b_bus_fwd_by_entry,
    input  logic [`IQ_ENTRIES-1:0][`CQ_INDEX_WIDTH-1:0] cq_index_by_entry,

    // pipeline issue
    output logic issue_valid,
    output logic issue_is_store,
    output logic issue_is_amo,
    output logic issue_is_fence,
    output logic [`OP_WIDTH-1:0] issue_op,
    output logic [`IMM_WIDTH-1:0] issue_imm12,
    output logic issue_a_is_reg,
    output logic issue_a_is_bus_forward,
    output logic [`LOG_PRF_BANK_COUNT-1:0] issue_a_bank,
    output logic issue_b_is_reg,
    output logic issue_b_is_bus_forward,
    output logic [`LOG_PRF_BANK_COUNT-1:0] issue_b_bank,
    output logic [`CQ_INDEX_WIDTH-1:0] issue_cq_index,

    // register file read requests
    output logic prf_req_a_valid,
    output logic [`LOG_PR_COUNT-1:0] prf_req_a_pr,
    output logic prf_req_b_valid,
    output logic [`LOG_PR_COUNT-1:0] prf_req_b_pr,

    output logic [`IQ_ENTRIES-1:0] collapse_mask
);

    logic [`IQ_ENTRIES-1:0] issue_req;
    logic [`IQ_ENTRIES-1:0] issue_one_hot;

    assign issue_req = {`IQ_ENTRIES{issue_ready}} & valid_by_entry
        & a_ready_by_entry & b_ready_by_entry;

    // oldest ready slot is the lowest index
    assign issue_one_hot = issue_req & (~issue_req + 1'b1);
    assign issue_valid = |issue_req;

    // ------------------------------------------------------------------------
    // one-hot issue mux and collapse mask

    always_comb begin
        logic seen;

        seen = 1'b0;
        issue_is_store = 1'b0;
        issue_is_amo = 1'b0;
        issue_is_fence = 1'b0;
        issue_op = '0;
        issue_imm12 = '0;
        issue_a_is_reg = 1'b0;
        issue_a_is_bus_forward = 1'b0;
        issue_a_bank = '0;
        issue_b_is_reg = 1'b0;
        issue_b_is_bus_forward = 1'b0;
        issue_b_bank = '0;
        issue_cq_index = '0;
        prf_req_a_valid = 1'b0;
        prf_req_a_pr = '0;
        prf_req_b_valid = 1'b0;
        prf_req_b_pr = '0;

        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            if (issue_one_hot[i]) begin
                issue_is_store |= is_store_by_entry[i];
                issue_is_amo |= is_amo_by_entry[i];
                issue_is_fence |= is_fence_by_entry[i];
                issue_op |= op_by_entry[i];
                issue_imm12 |= imm12_by_entry[i];
                issue_a_is_reg |= ~(a_is_zero_by_entry[i] | a_bus_fwd_by_entry[i]);
                issue_a_is_bus_forward |= a_bus_fwd_by_entry[i];
                issue_a_bank |= a_pr_by_entry[i].f.bank;
                issue_b_is_reg |= ~(b_is_zero_by_entry[i] | b_bus_fwd_by_entry[i]);
                issue_b_is_bus_forward |= b_bus_fwd_by_entry[i];
                issue_b_bank |= b_pr_by_entry[i].f.bank;
                issue_cq_index |= cq_index_by_entry[i];
                prf_req_a_valid |= ~(a_is_zero_by_entry[i] | a_bus_fwd_by_entry[i]);
                prf_req_a_pr |= a_pr_by_entry[i].idx;
                prf_req_b_valid |= ~(b_is_zero_by_entry[i] | b_bus_fwd_by_entry[i]);
                prf_req_b_pr |= b_pr_by_entry[i].idx;
            end

            // issued slot and everything above shift down
            seen = seen | issue_one_hot[i];
            collapse_mask[i] = seen;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the store/AMO/fence issue queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f vlog.f \
    --top-module stamofu_iq_tb -o stamofu_iq_sim

output=$(./obj_dir/stamofu_iq_sim)
echo "$output"

# a missing pass line makes grep, and so the script, fail
echo "$output" | grep -qx "Result: PASSED"

//--- verification/stamofu_iq_tb.sv
`include "iq_defs.svh"

module stamofu_iq_tb;

    localparam int BANK_W = `LOG_PRF_BANK_COUNT;
    localparam int PR_W = `LOG_PR_COUNT;
    // the tests take about 70 cycles, so this leaves a wide margin
    localparam int CYCLE_LIMIT = 2000;

    typedef struct packed {
        logic [2:0] kind;
        logic [`OP_WIDTH-1:0] op;
        logic [`IMM_WIDTH-1:0] imm;
        logic [PR_W-1:0] a_pr;
        logic a_rdy;
        logic a_zero;
        logic [PR_W-1:0] b_pr;
        logic b_rdy;
        logic b_zero;
        logic [`CQ_INDEX_WIDTH-1:0] cq;
    } op_t;

    logic CLK;
    logic nRST;
    logic enq_valid;
    logic enq_is_store;
    logic enq_is_amo;
    logic enq_is_fence;
    logic [`OP_WIDTH-1:0] enq_op;
    logic [`IMM_WIDTH-1:0] enq_imm12;
    logic [PR_W-1:0] enq_a_pr;
    logic enq_a_ready;
    logic enq_a_is_zero;
    logic [PR_W-1:0] enq_b_pr;
    logic enq_b_ready;
    logic enq_b_is_zero;
    logic [`CQ_INDEX_WIDTH-1:0] enq_cq_index;
    logic enq_ready;
    logic [`PRF_BANK_COUNT-1:0] wb_valid_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PR_UPPER_WIDTH-1:0] wb_upper_pr_by_bank;
    logic issue_ready;
    logic issue_valid;
    logic issue_is_store;
    logic issue_is_amo;
    logic issue_is_fence;
    logic [`OP_WIDTH-1:0] issue_op;
    logic [`IMM_WIDTH-1:0] issue_imm12;
    logic issue_a_is_reg;
    logic issue_a_is_bus_forward;
    logic [BANK_W-1:0] issue_a_bank;
    logic issue_b_is_reg;
    logic issue_b_is_bus_forward;
    logic [BANK_W-1:0] issue_b_bank;
    logic [`CQ_INDEX_WIDTH-1:0] issue_cq_index;
    logic prf_req_a_valid;
    logic [PR_W-1:0] prf_req_a_pr;
    logic prf_req_b_valid;
    logic [PR_W-1:0] prf_req_b_pr;

    op_t model_q[$];
    string test_name;
    int value_errors = 0;
    int protocol_errors = 0;
    int cycle_count = 0;
    logic [31:0] lcg_state = 32'h99a86215;

    stamofu_iq stamofu_iq_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // ------------------------------------------------------------------------
    // reference model

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [PR_W-1:0] random_pr();
        logic [31:0] r;
        r = next_random();
        return r[29:24];
    endfunction

    // bank in the low bits, upper part above it
    function automatic logic wb_match(input logic [PR_W-1:0] pr, input logic is_zero);
        logic [BANK_W-1:0] bank;
        bank = pr[BANK_W-1:0];
        return !is_zero && wb_valid_by_bank[bank]
            && (wb_upper_pr_by_bank[bank] == pr[PR_W-1:BANK_W]);
    endfunction

    function automatic logic operands_ready(input op_t e);
        return (e.a_rdy | e.a_zero | wb_match(e.a_pr, e.a_zero))
            & (e.b_rdy | e.b_zero | wb_match(e.b_pr, e.b_zero));
    endfunction

    function automatic int oldest_ready();
        int idx;
        idx = -1;
        if (issue_ready) begin
            for (int i = model_q.size() - 1; i >= 0; i--) begin
                if (operands_ready(model_q[i])) begin
                    idx = i;
                end
            end
        end
        return idx;
    endfunction

    task automatic check_field(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected == actual) else begin
            value_errors++;
            $display("Error %s: %s expected %0h actual %0h", test_name, field, expected, actual);
        end
    endtask

    task automatic check_outputs();
        int idx;
        op_t e;
        logic a_hit;
        logic b_hit;
        idx = oldest_ready();
        check_field("enq_ready", 64'(model_q.size() < `IQ_ENTRIES), 64'(enq_ready));
        check_field("issue_valid", 64'(idx >= 0), 64'(issue_valid));
        if (idx >= 0) begin
            e = model_q[idx];
            a_hit = wb_match(e.a_pr, e.a_zero);
            b_hit = wb_match(e.b_pr, e.b_zero);
            check_field("kind", 64'(e.kind), 64'({issue_is_store, issue_is_amo, issue_is_fence}));
            check_field("op", 64'(e.op), 64'(issue_op));
            check_field("imm12", 64'(e.imm), 64'(issue_imm12));
            check_field("cq_index", 64'(e.cq), 64'(issue_cq_index));
            check_field("a_is_reg", 64'(!e.a_zero && !a_hit), 64'(issue_a_is_reg));
            check_field("a_bus_forward", 64'(a_hit), 64'(issue_a_is_bus_forward));
            check_field("a_bank", 64'(e.a_pr[BANK_W-1:0]), 64'(issue_a_bank));
            check_field("prf_req_a_valid", 64'(!e.a_zero && !a_hit), 64'(prf_req_a_valid));
            check_field("prf_req_a_pr", 64'(e.a_pr), 64'(prf_req_a_pr));
            check_field("b_is_reg", 64'(!e.b_zero && !b_hit), 64'(issue_b_is_reg));
            check_field("b_bus_forward", 64'(b_hit), 64'(issue_b_is_bus_forward));
            check_field("b_bank", 64'(e.b_pr[BANK_W-1:0]), 64'(issue_b_bank));
            check_field("prf_req_b_valid", 64'(!e.b_zero && !b_hit), 64'(prf_req_b_valid));
            check_field("prf_req_b_pr", 64'(e.b_pr), 64'(prf_req_b_pr));
        end else begin
            check_field("idle issue outputs", 64'd0, 64'({issue_is_store, issue_is_amo,
                issue_is_fence, issue_op, issue_imm12, issue_a_is_reg, issue_a_is_bus_forward,
                issue_a_bank, issue_b_is_reg, issue_b_is_bus_forward, issue_b_bank,
                issue_cq_index, prf_req_a_valid, prf_req_a_pr, prf_req_b_valid, prf_req_b_pr}));
        end
    endtask

    task automatic update_model();
        int idx;
        logic room;
        op_t e;
        idx = oldest_ready();
        room = model_q.size() < `IQ_ENTRIES;
        if (idx >= 0) begin
            model_q.delete(idx);
        end
        // operands seen on the bus stay ready
        foreach (model_q[i]) begin
            e = model_q[i];
            e.a_rdy = e.a_rdy | wb_match(e.a_pr, e.a_zero);
            e.b_rdy = e.b_rdy | wb_match(e.b_pr, e.b_zero);
            model_q[i] = e;
        end
        if (enq_valid && room) begin
            e.kind = {enq_is_store, enq_is_amo, enq_is_fence};
            e.op = enq_op;
            e.imm = enq_imm12;
            e.a_pr = enq_a_pr;
            e.a_rdy = enq_a_ready;
            e.a_zero = enq_a_is_zero;
            e.b_pr = enq_b_pr;
            e.b_rdy = enq_b_ready;
            e.b_zero = enq_b_is_zero;
            e.cq = enq_cq_index;
            model_q.push_back(e);
        end
    endtask

    always @(posedge CLK) begin
        if (nRST) begin
            check_outputs();
            update_model();
        end
    end

    assert property (@(posedge CLK) issue_ready || !issue_valid)
        else begin
            protocol_errors++;
            $display("issue_valid was high while issue_ready was low");
        end

    task automatic print_error_counts();
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    endtask

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            print_error_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus, driven on the falling edge

    task automatic step();
        @(negedge CLK);
        enq_valid = 1'b0;
        wb_valid_by_bank = '0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) step();
    endtask

    task automatic set_enqueue(input logic [PR_W-1:0] a_pr, input logic a_rdy,
                               input logic a_zero, input logic [PR_W-1:0] b_pr,
                               input logic b_rdy, input logic b_zero);
        logic [31:0] r;
        int kind;
        r = next_random();
        kind = int'(r[12:5]) % 3;
        enq_valid = 1'b1;
        enq_is_store = (kind == 0);
        enq_is_amo = (kind == 1);
        enq_is_fence = (kind == 2);
        enq_op = r[31:28];
        enq_imm12 = r[27:16];
        enq_cq_index = r[15:13];
        enq_a_pr = a_pr;
        enq_a_ready = a_rdy;
        enq_a_is_zero = a_zero;
        enq_b_pr = b_pr;
        enq_b_ready = b_rdy;
        enq_b_is_zero = b_zero;
    endtask

    task automatic enqueue_ready_op();
        set_enqueue(random_pr(), 1'b1, 1'b0, random_pr(), 1'b1, 1'b0);
        step();
    endtask

    task automatic set_writeback(input logic [PR_W-1:0] pr);
        wb_valid_by_bank[pr[BANK_W-1:0]] = 1'b1;
        wb_upper_pr_by_bank[pr[BANK_W-1:0]] = pr[PR_W-1:BANK_W];
    endtask

    task automatic wait_drain();
        while (model_q.size() != 0) begin
            step();
        end
    endtask

    initial begin
        nRST = 1'b0;
        issue_ready = 1'b0;
        enq_valid = 1'b0;
        enq_is_store = 1'b0;
        enq_is_amo = 1'b0;
        enq_is_fence = 1'b0;
        enq_op = '0;
        enq_imm12 = '0;
        enq_a_pr = '0;
        enq_a_ready = 1'b0;
        enq_a_is_zero = 1'b0;
        enq_b_pr = '0;
        enq_b_ready = 1'b0;
        enq_b_is_zero = 1'b0;
        enq_cq_index = '0;
        wb_valid_by_bank = '0;
        wb_upper_pr_by_bank = '0;
        test_name = "reset";
        repeat (4) @(negedge CLK);
        nRST = 1'b1;
        idle(3);

        // queue builds up, then drains while new ops arrive
        test_name = "in_order";
        repeat (3) enqueue_ready_op();
        issue_ready = 1'b1;
        repeat (5) enqueue_ready_op();
        wait_drain();

        test_name = "wakeup";
        set_enqueue(6'h2d, 1'b0, 1'b0, random_pr(), 1'b1, 1'b0);
        step();
        set_enqueue(6'h2d, 1'b0, 1'b0, random_pr(), 1'b1, 1'b0);
        step();
        idle(2);
        // same upper part on another bank
        set_writeback(6'h2e);
        step();
        set_writeback(6'h2d);
        step();
        wait_drain();
        // a woken early while b's bank carries another register
        set_enqueue(6'h0a, 1'b0, 1'b0, 6'h13, 1'b0, 1'b0);
        step();
        set_writeback(6'h0a);
        set_writeback(6'h1b);
        step();
        set_writeback(6'h13);
        step();
        wait_drain();

        test_name = "zero_operand";
        set_enqueue(6'h08, 1'b0, 1'b1, random_pr(), 1'b1, 1'b0);
        step();
        wait_drain();
        set_enqueue(6'h20, 1'b0, 1'b1, 6'h17, 1'b0, 1'b0);
        step();
        idle(1);
        set_writeback(6'h20);
        set_writeback(6'h17);
        step();
        wait_drain();
        set_enqueue(random_pr(), 1'b0, 1'b1, random_pr(), 1'b0, 1'b1);
        step();
        wait_drain();

        test_name = "full_queue";
        issue_ready = 1'b0;
        repeat (`IQ_ENTRIES) enqueue_ready_op();
        idle(2);
        issue_ready = 1'b1;
        wait_drain();

        test_name = "younger_first";
        issue_ready = 1'b0;
        set_enqueue(6'h35, 1'b0, 1'b0, random_pr(), 1'b1, 1'b0);
        step();
        repeat (3) enqueue_ready_op();
        set_enqueue(random_pr(), 1'b1, 1'b0, 6'h35, 1'b0, 1'b0);
        step();
        idle(2);
        issue_ready = 1'b1;
        step();
        set_writeback(6'h35);
        step();
        wait_drain();
        idle(3);

        print_error_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/prf_pkg.sv
hdl/stamofu_iq_entry.sv
hdl/stamofu_iq_dispatch.sv
hdl/stamofu_iq_issue.sv
hdl/stamofu_iq.sv
verification/stamofu_iq_tb.sv
